// File: src/mgmt_settings.svh
`ifndef MGMT_SETTINGS_SVH
`define MGMT_SETTINGS_SVH

//////////////////////////////////////////////////
// Register bus geometry

`define MGMT_ADDR_W 16
`define MGMT_DATA_W 8

//////////////////////////////////////////////////
// MDIO channel layout

// Channel n register block starts at n * stride
`define MDIO_CHANNELS 3
`define MDIO_REG_STRIDE 8

// sys_clk cycles per MDC half period
`define MDIO_DIV_FAST 4
`define MDIO_DIV_SLOW 10

// Channel 1 MDC held low this many cycles after reset
`define MDIO_HOLDOFF 64

`define MDIO_PREAMBLE_LEN 32

`endif

// File: src/mgmt_pkg.sv
package mgmt_pkg;

	//////////////////////////////////////////////////
	// Register offsets inside one channel block

	typedef enum logic [2:0] {
		REG_CMD      = 3'd0,	// Bit 7 write, bits 4:0 register address
		REG_PHY_ADDR = 3'd1,
		REG_WDATA_LO = 3'd2,
		REG_WDATA_HI = 3'd3,
		REG_STATUS   = 3'd4,	// Bit 0 busy
		REG_RDATA_LO = 3'd5,
		REG_RDATA_HI = 3'd6
	} mgmt_reg_t;

	// Clause 22 opcodes as sent on the wire
	typedef enum logic [1:0] {
		MDIO_OP_WRITE = 2'b01,
		MDIO_OP_READ  = 2'b10
	} mdio_op_t;

	// Frame engine states
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_HEADER,
		ST_TURNAROUND,
		ST_DATA,
		ST_DONE
	} mdio_state_t;

endpackage

// File: src/mdio_reg_decoder.sv
`timescale 1ns/1ns
`include "mgmt_settings.svh"

module mdio_reg_decoder (
	input  logic                                sys_clk,
	input  logic                                arst_n,
	input  logic                                wr_en,
	input  logic [`MGMT_ADDR_W-1:0]             wr_addr,
	input  logic [`MGMT_DATA_W-1:0]             wr_data,
	output logic [`MDIO_CHANNELS-1:0][4:0]      phy_md_addr,
	output logic [`MDIO_CHANNELS-1:0][4:0]      phy_reg_addr,
	output logic [`MDIO_CHANNELS-1:0][15:0]     phy_wr_data,
	output logic [`MDIO_CHANNELS-1:0]           phy_reg_wr,
	output logic [`MDIO_CHANNELS-1:0]           phy_reg_rd
);
	import mgmt_pkg::*;

	// Offset bits inside a channel block, channel index above them
	localparam int OFS_W  = $clog2(`MDIO_REG_STRIDE);
	localparam int CHAN_W = `MGMT_ADDR_W - OFS_W;

	logic                     wr_en_ff;
	logic [`MGMT_ADDR_W-1:0]  wr_addr_ff;
	logic [`MGMT_DATA_W-1:0]  wr_data_ff;
	logic [CHAN_W-1:0]        wr_chan;
	mgmt_reg_t                wr_reg;

	//////////////////////////////////////////////////
	// Write pipeline stage

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_en_ff <= 1'b0;
		end else begin
			wr_en_ff <= wr_en;
		end
	end

	// Address and data only qualified by wr_en_ff
	always_ff @(posedge sys_clk) begin
		wr_addr_ff <= wr_addr;
		wr_data_ff <= wr_data;
	end

	// Split registered address into channel and offset
	assign wr_chan = wr_addr_ff[`MGMT_ADDR_W-1:OFS_W];
	assign wr_reg  = mgmt_reg_t'(wr_addr_ff[OFS_W-1:0]);

	//////////////////////////////////////////////////
	// Per-channel held registers and command strobes

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			phy_md_addr  <= '0;
			phy_reg_addr <= '0;
			phy_wr_data  <= '0;
			phy_reg_wr   <= '0;
			phy_reg_rd   <= '0;
		end else begin
			// Strobes last one cycle only
			phy_reg_wr <= '0;
			phy_reg_rd <= '0;
			for (int i = 0; i < `MDIO_CHANNELS; i++) begin
				if (wr_en_ff && (wr_chan == i)) begin
					case (wr_reg)
						REG_CMD: begin
							phy_reg_addr[i] <= wr_data_ff[4:0];
							// Bit 7 picks frame direction
							if (wr_data_ff[7]) begin
								phy_reg_wr[i] <= 1'b1;
							end else begin
								phy_reg_rd[i] <= 1'b1;
							end
						end
						REG_PHY_ADDR: phy_md_addr[i] <= wr_data_ff[4:0];
						REG_WDATA_LO: phy_wr_data[i][7:0] <= wr_data_ff;
						REG_WDATA_HI: phy_wr_data[i][15:8] <= wr_data_ff;
						// Read-only and unmapped offsets
						default: ;
					endcase
				end
			end
		end
	end

endmodule

// File: src/mdio_master.sv
`timescale 1ns/1ns
`include "mgmt_settings.svh"

module mdio_master #(
	parameter int CLK_DIV = 4,
	parameter int HOLDOFF = 0
) (
	input  logic        sys_clk,
	input  logic        arst_n,
	input  logic [4:0]  phy_md_addr,
	input  logic [4:0]  phy_reg_addr,
	input  logic [15:0] phy_wr_data,
	input  logic        phy_reg_wr,
	input  logic        phy_reg_rd,
	input  logic        mdio_in,
	output logic        busy,
	output logic [15:0] phy_rd_data,
	output logic        mdc,
	output logic        mdio_out,
	output logic        mdio_oe
);
	import mgmt_pkg::*;

	localparam int DIV_W  = $clog2(CLK_DIV + 1);
	localparam int HOLD_W = $clog2(HOLDOFF + 2);
	localparam int CNT_W  = $clog2(`MDIO_PREAMBLE_LEN);

	logic [DIV_W-1:0]  div_cnt;
	logic              mdc_raw;
	logic              div_tick;
	logic [HOLD_W-1:0] hold_cnt;
	logic              mdc_en;
	logic              fall_evt;
	logic              rise_evt;

	mdio_state_t       state;
	mdio_op_t          op_sel;
	logic [CNT_W-1:0]  bit_cnt;
	logic              bit_live;
	logic              is_read;
	logic [13:0]       hdr_sreg;
	logic [15:0]       data_sreg;

	//////////////////////////////////////////////////
	// MDC divider and hold-off gate

	assign div_tick = (div_cnt == DIV_W'(CLK_DIV - 1));

	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt  <= '0;
			mdc_raw  <= 1'b0;
			hold_cnt <= HOLD_W'(HOLDOFF);
			mdc_en   <= (HOLDOFF == 0);
		end else begin
			div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
			if (div_tick) begin
				mdc_raw <= ~mdc_raw;
			end
			// Count down, then ungate for good
			if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end else begin
				mdc_en <= 1'b1;
			end
		end
	end

	assign mdc = mdc_raw & mdc_en;

	// Edge events line up with the MDC transition itself
	assign fall_evt = div_tick & mdc_raw & mdc_en;
	assign rise_evt = div_tick & ~mdc_raw & mdc_en;

	assign op_sel = phy_reg_wr ? MDIO_OP_WRITE : MDIO_OP_READ;

	//////////////////////////////////////////////////
	// Frame engine

	// Falling edge drives a bit, rising edge closes its period
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= ST_IDLE;
			bit_cnt     <= '0;
			bit_live    <= 1'b0;
			is_read     <= 1'b0;
			busy        <= 1'b0;
			mdio_out    <= 1'b1;
			mdio_oe     <= 1'b0;
			hdr_sreg    <= '0;
			data_sreg   <= '0;
			phy_rd_data <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// New commands only accepted here
					if (phy_reg_wr || phy_reg_rd) begin
						hdr_sreg  <= {2'b01, op_sel, phy_md_addr, phy_reg_addr};
						data_sreg <= phy_wr_data;
						is_read   <= (op_sel == MDIO_OP_READ);
						bit_cnt   <= CNT_W'(`MDIO_PREAMBLE_LEN - 1);
						bit_live  <= 1'b0;
						busy      <= 1'b1;
						state     <= ST_PREAMBLE;
					end
				end
				ST_DONE: begin
					// Final MDC period over, bus released
					if (fall_evt) begin
						mdio_oe  <= 1'b0;
						mdio_out <= 1'b1;
						busy     <= 1'b0;
						if (is_read) begin
							phy_rd_data <= data_sreg;
						end
						state <= ST_IDLE;
					end
				end
				default: begin
					if (fall_evt) begin
						bit_live <= 1'b1;
						case (state)
							ST_PREAMBLE: begin
								mdio_oe  <= 1'b1;
								mdio_out <= 1'b1;
							end
							ST_HEADER: mdio_out <= hdr_sreg[13];
							ST_TURNAROUND: begin
								// PHY owns the line from here on reads
								if (is_read) begin
									mdio_oe <= 1'b0;
								end else begin
									mdio_out <= bit_cnt[0];
								end
							end
							default: begin
								if (!is_read) begin
									mdio_out <= data_sreg[15];
								end
							end
						endcase
					end else if (rise_evt && bit_live) begin
						bit_live <= 1'b0;
						if (state == ST_HEADER) begin
							hdr_sreg <= {hdr_sreg[12:0], 1'b0};
						end
						// Same register shifts write data out, read data in
						if (state == ST_DATA) begin
							data_sreg <= {data_sreg[14:0], is_read & mdio_in};
						end
						if (bit_cnt != '0) begin
							bit_cnt <= bit_cnt - 1'b1;
						end else begin
							case (state)
								ST_PREAMBLE: begin
									bit_cnt <= CNT_W'(13);
									state   <= ST_HEADER;
								end
								ST_HEADER: begin
									bit_cnt <= CNT_W'(1);
									state   <= ST_TURNAROUND;
								end
								ST_TURNAROUND: begin
									bit_cnt <= CNT_W'(15);
									state   <= ST_DATA;
								end
								default: state <= ST_DONE;
							endcase
						end
					end
				end
			endcase
		end
	end

endmodule

// File: src/mdio_readback_mux.sv
`timescale 1ns/1ns
`include "mgmt_settings.svh"

module mdio_readback_mux (
	input  logic                             sys_clk,
	input  logic                             arst_n,
	input  logic                             rd_en,
	input  logic [`MGMT_ADDR_W-1:0]          rd_addr,
	input  logic [`MDIO_CHANNELS-1:0]        busy,
	input  logic [`MDIO_CHANNELS-1:0][15:0]  phy_rd_data,
	output logic                             rd_valid,
	output logic [`MGMT_DATA_W-1:0]          rd_data
);
	import mgmt_pkg::*;

	localparam int OFS_W  = $clog2(`MDIO_REG_STRIDE);
	localparam int CHAN_W = `MGMT_ADDR_W - OFS_W;

	logic [CHAN_W-1:0]       rd_chan;
	mgmt_reg_t               rd_reg;
	logic [`MGMT_DATA_W-1:0] rd_byte;

	assign rd_chan = rd_addr[`MGMT_ADDR_W-1:OFS_W];
	assign rd_reg  = mgmt_reg_t'(rd_addr[OFS_W-1:0]);

	//////////////////////////////////////////////////
	// Byte select, zero when nothing matches

	always_comb begin
		rd_byte = '0;
		for (int i = 0; i < `MDIO_CHANNELS; i++) begin
			if (rd_chan == i) begin
				case (rd_reg)
					REG_STATUS:   rd_byte = {7'b0, busy[i]};
					REG_RDATA_LO: rd_byte = phy_rd_data[i][7:0];
					REG_RDATA_HI: rd_byte = phy_rd_data[i][15:8];
					default:      rd_byte = '0;
				endcase
			end
		end
	end

	// Answer lands one cycle after rd_en
	always_ff @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid <= 1'b0;
			rd_data  <= '0;
		end else begin
			rd_valid <= rd_en;
			if (rd_en) begin
				rd_data <= rd_byte;
			end
		end
	end

endmodule

// File: src/mgmt_mdio_top.sv
`timescale 1ns/1ns
`include "mgmt_settings.svh"

module mgmt_mdio_top (
	input  logic                       sys_clk,
	input  logic                       arst_n,
	input  logic                       wr_en,
	input  logic [`MGMT_ADDR_W-1:0]    wr_addr,
	input  logic [`MGMT_DATA_W-1:0]    wr_data,
	input  logic                       rd_en,
	input  logic [`MGMT_ADDR_W-1:0]    rd_addr,
	input  logic [`MDIO_CHANNELS-1:0]  mdio_in,
	output logic                       rd_valid,
	output logic [`MGMT_DATA_W-1:0]    rd_data,
	output logic [`MDIO_CHANNELS-1:0]  mdc,
	output logic [`MDIO_CHANNELS-1:0]  mdio_out,
	output logic [`MDIO_CHANNELS-1:0]  mdio_oe
);

	logic [`MDIO_CHANNELS-1:0][4:0]  phy_md_addr;
	logic [`MDIO_CHANNELS-1:0][4:0]  phy_reg_addr;
	logic [`MDIO_CHANNELS-1:0][15:0] phy_wr_data;
	logic [`MDIO_CHANNELS-1:0][15:0] phy_rd_data;
	logic [`MDIO_CHANNELS-1:0]       phy_reg_wr;
	logic [`MDIO_CHANNELS-1:0]       phy_reg_rd;
	logic [`MDIO_CHANNELS-1:0]       busy;

	//////////////////////////////////////////////////
	// Bus write side

	mdio_reg_decoder u_decoder (
		.sys_clk      (sys_clk),
		.arst_n       (arst_n),
		.wr_en        (wr_en),
		.wr_addr      (wr_addr),
		.wr_data      (wr_data),
		.phy_md_addr  (phy_md_addr),
		.phy_reg_addr (phy_reg_addr),
		.phy_wr_data  (phy_wr_data),
		.phy_reg_wr   (phy_reg_wr),
		.phy_reg_rd   (phy_reg_rd)
	);

	//////////////////////////////////////////////////
	// MDIO channels

	// Channel 2 runs slow, channel 1 waits out the hold-off
	for (genvar ch = 0; ch < `MDIO_CHANNELS; ch++) begin : g_chan
		mdio_master #(
			.CLK_DIV ((ch == 2) ? `MDIO_DIV_SLOW : `MDIO_DIV_FAST),
			.HOLDOFF ((ch == 1) ? `MDIO_HOLDOFF : 0)
		) u_master (
			.sys_clk      (sys_clk),
			.arst_n       (arst_n),
			.phy_md_addr  (phy_md_addr[ch]),
			.phy_reg_addr (phy_reg_addr[ch]),
			.phy_wr_data  (phy_wr_data[ch]),
			.phy_reg_wr   (phy_reg_wr[ch]),
			.phy_reg_rd   (phy_reg_rd[ch]),
			.mdio_in      (mdio_in[ch]),
			.busy         (busy[ch]),
			.phy_rd_data  (phy_rd_data[ch]),
			.mdc          (mdc[ch]),
			.mdio_out     (mdio_out[ch]),
			.mdio_oe      (mdio_oe[ch])
		);
	end

	// Status and read data back onto the bus
	mdio_readback_mux u_readback (
		.sys_clk     (sys_clk),
		.arst_n      (arst_n),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.busy        (busy),
		.phy_rd_data (phy_rd_data),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data)
	);

endmodule

// File: sim/mdio_phy_model.sv
`timescale 1ns/1ns

module mdio_phy_model #(
	parameter int CHANNEL = 0
) (
	input  logic        mdc,
	input  logic        mdio_out,
	input  logic        mdio_oe,
	output logic        mdio_in,
	output logic [4:0]  last_phy,
	output logic [4:0]  last_reg,
	output logic [1:0]  last_op,
	output logic [15:0] stored,
	output logic [15:0] frames
);

	logic [15:0] regs [32];
	logic [11:0] hdr;
	logic [15:0] wr_shift;
	logic [15:0] rd_word;
	logic        prev_bit;
	logic        in_frame;
	logic        is_write;
	int          pos;

	// Register file starts at index * 0x0101 plus channel number
	initial begin
		for (int i = 0; i < 32; i++) begin
			regs[i] = 16'(i * 16'h0101 + CHANNEL);
		end
		hdr      = '0;
		wr_shift = '0;
		rd_word  = '0;
		prev_bit = 1'b1;
		in_frame = 1'b0;
		is_write = 1'b0;
		pos      = 0;
		mdio_in  = 1'b1;
		last_phy = '0;
		last_reg = '0;
		last_op  = '0;
		frames   = '0;
	end

	// Value at the most recently addressed register
	assign stored = regs[last_reg];

	//////////////////////////////////////////////////
	// Frame decode on MDC rising edge

	// Bit positions count from after the start bits
	// Header 0 to 11, turnaround 12 and 13, data 14 to 29
	always @(posedge mdc) begin
		if (!in_frame) begin
			// Start pattern 01 right after the preamble ones
			if (mdio_oe && !prev_bit && mdio_out) begin
				in_frame = 1'b1;
				pos      = 0;
			end
			prev_bit = mdio_oe ? mdio_out : 1'b1;
		end else begin
			if (pos < 12 && mdio_oe) begin
				hdr = {hdr[10:0], mdio_out};
			end
			// Header complete with opcode, PHY address and register address
			if (pos == 11) begin
				last_op  <= hdr[11:10];
				last_phy <= hdr[9:5];
				last_reg <= hdr[4:0];
				is_write = (hdr[11:10] == 2'b01);
				rd_word  = regs[hdr[4:0]];
			end
			if (pos >= 14 && is_write && mdio_oe) begin
				wr_shift = {wr_shift[14:0], mdio_out};
			end
			if (pos == 29) begin
				if (is_write) begin
					regs[hdr[4:0]] = wr_shift;
				end
				frames  <= frames + 1'b1;
				in_frame = 1'b0;
				prev_bit = 1'b1;
			end
			pos++;
		end
	end

	// Read data goes out MSB first on MDC falling edge
	always @(negedge mdc) begin
		if (in_frame && !is_write && pos >= 14) begin
			// A master still driving the line corrupts the bit
			mdio_in <= mdio_oe ? 1'bx : rd_word[29 - pos];
		end else begin
			mdio_in <= 1'b1;
		end
	end

endmodule

// File: sim/tb_mgmt_mdio.sv
`timescale 1ns/1ns
`include "mgmt_settings.svh"

module tb_mgmt_mdio;
	import mgmt_pkg::*;

	logic                             sys_clk;
	logic                             arst_n;
	logic                             wr_en;
	logic                             rd_en;
	logic                             rd_valid;
	logic [`MGMT_ADDR_W-1:0]          wr_addr;
	logic [`MGMT_ADDR_W-1:0]          rd_addr;
	logic [`MGMT_DATA_W-1:0]          wr_data;
	logic [`MGMT_DATA_W-1:0]          rd_data;
	logic [`MDIO_CHANNELS-1:0]        mdc;
	logic [`MDIO_CHANNELS-1:0]        mdio_out;
	logic [`MDIO_CHANNELS-1:0]        mdio_oe;
	logic [`MDIO_CHANNELS-1:0]        mdio_in;

	// Model observations per channel
	logic [`MDIO_CHANNELS-1:0][4:0]   m_phy;
	logic [`MDIO_CHANNELS-1:0][4:0]   m_reg;
	logic [`MDIO_CHANNELS-1:0][1:0]   m_op;
	logic [`MDIO_CHANNELS-1:0][15:0]  m_stored;
	logic [`MDIO_CHANNELS-1:0][15:0]  m_frames;

	// Expected frame contents per channel
	logic [`MDIO_CHANNELS-1:0][4:0]   exp_phy;
	logic [`MDIO_CHANNELS-1:0][4:0]   exp_reg;
	logic [`MDIO_CHANNELS-1:0][15:0]  exp_dat;

	logic [31:0] rng;
	int          errors;
	int          tests;
	int          err_mark;
	int          cyc;

	mgmt_mdio_top u_dut (
		.sys_clk  (sys_clk),
		.arst_n   (arst_n),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.rd_en    (rd_en),
		.rd_addr  (rd_addr),
		.mdio_in  (mdio_in),
		.rd_valid (rd_valid),
		.rd_data  (rd_data),
		.mdc      (mdc),
		.mdio_out (mdio_out),
		.mdio_oe  (mdio_oe)
	);

	for (genvar ch = 0; ch < `MDIO_CHANNELS; ch++) begin : g_phy
		mdio_phy_model #(.CHANNEL(ch)) u_phy (
			.mdc      (mdc[ch]),
			.mdio_out (mdio_out[ch]),
			.mdio_oe  (mdio_oe[ch]),
			.mdio_in  (mdio_in[ch]),
			.last_phy (m_phy[ch]),
			.last_reg (m_reg[ch]),
			.last_op  (m_op[ch]),
			.stored   (m_stored[ch]),
			.frames   (m_frames[ch])
		);
	end

	initial begin
		sys_clk = 1'b0;
		forever #50 sys_clk = ~sys_clk;
	end

	// Cycles since reset release up to the hold-off length
	always @(posedge sys_clk or negedge arst_n) begin
		if (!arst_n) begin
			cyc <= 0;
		end else if (cyc < `MDIO_HOLDOFF) begin
			cyc <= cyc + 1;
		end
	end

	//////////////////////////////////////////////////
	// Concurrent checks

	// rd_valid high exactly one cycle after rd_en and at no other time
	assert property (@(posedge sys_clk) disable iff (!arst_n) rd_valid == $past(rd_en))
	else begin
		errors++;
		$display("Mismatch at %0t: rd_valid %0b does not follow rd_en", $time, rd_valid);
	end

	// Channel 1 MDC gated low during the hold-off
	assert property (@(posedge sys_clk) disable iff (!arst_n)
		(cyc < `MDIO_HOLDOFF) |-> !mdc[1])
	else begin
		errors++;
		$display("Mismatch at %0t: channel 1 MDC high during hold-off", $time);
	end

	//////////////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] next_rand();
		rng = rng * 32'd1103515245 + 32'd12345;
		return rng;
	endfunction

	function automatic logic [15:0] reg_addr(input int ch, input logic [2:0] ofs);
		return 16'(ch * `MDIO_REG_STRIDE) + 16'(ofs);
	endfunction

	task automatic check_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
		assert (got === exp) else begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == err_mark) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	// Inputs change on the falling edge only
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(negedge sys_clk);
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge sys_clk);
		wr_en = 1'b0;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		int n;
		@(negedge sys_clk);
		rd_en   = 1'b1;
		rd_addr = addr;
		@(negedge sys_clk);
		rd_en = 1'b0;
		n = 0;
		while (!rd_valid && n < 4) begin
			@(negedge sys_clk);
			n++;
		end
		if (!rd_valid) begin
			errors++;
			$display("Read of address %h never returned rd_valid", addr);
		end
		data = rd_data;
	endtask

	// Poll status until busy reaches the wanted level
	task automatic wait_busy(input int ch, input logic level);
		logic [7:0] st;
		int         polls;
		polls = 0;
		bus_read(reg_addr(ch, REG_STATUS), st);
		while (st[0] !== level && polls < 2000) begin
			bus_read(reg_addr(ch, REG_STATUS), st);
			polls++;
		end
		if (st[0] !== level) begin
			errors++;
			$display("Timeout: channel %0d busy never went to %0b", ch, level);
		end
	endtask

	// PHY address and write data ahead of the command
	task automatic load_write(input int ch);
		bus_write(reg_addr(ch, REG_PHY_ADDR), {3'b000, exp_phy[ch]});
		bus_write(reg_addr(ch, REG_WDATA_LO), exp_dat[ch][7:0]);
		bus_write(reg_addr(ch, REG_WDATA_HI), exp_dat[ch][15:8]);
	endtask

	task automatic check_write(input int ch, input logic [15:0] frames_before);
		check_eq(m_phy[ch], exp_phy[ch], $sformatf("ch%0d PHY address", ch));
		check_eq(m_reg[ch], exp_reg[ch], $sformatf("ch%0d register address", ch));
		check_eq(m_op[ch], 2'b01, $sformatf("ch%0d write opcode", ch));
		check_eq(m_stored[ch], exp_dat[ch], $sformatf("ch%0d stored value", ch));
		check_eq(m_frames[ch], frames_before + 1'b1, $sformatf("ch%0d frame count", ch));
	endtask

	task automatic read_and_check(input int ch, input logic [4:0] ra, input logic [15:0] exp);
		logic [7:0] lo;
		logic [7:0] hi;
		bus_write(reg_addr(ch, REG_CMD), {3'b000, ra});
		wait_busy(ch, 1'b1);
		wait_busy(ch, 1'b0);
		bus_read(reg_addr(ch, REG_RDATA_LO), lo);
		bus_read(reg_addr(ch, REG_RDATA_HI), hi);
		check_eq({hi, lo}, exp, $sformatf("ch%0d read of register %0d", ch, ra));
		check_eq(m_op[ch], 2'b10, $sformatf("ch%0d read opcode", ch));
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [31:0]                      r;
		logic [7:0]                       rd;
		logic [2:0]                       seen;
		logic [`MDIO_CHANNELS-1:0][15:0]  base_fr;
		logic [4:0]                       alt;
		int                               n;
		wr_en    = 1'b0;
		wr_addr  = '0;
		wr_data  = '0;
		rd_en    = 1'b0;
		rd_addr  = '0;
		arst_n   = 1'b0;
		rng      = 32'd43;
		errors   = 0;
		tests    = 0;
		err_mark = 0;
		repeat (10) @(posedge sys_clk);
		@(negedge sys_clk);
		arst_n = 1'b1;

		// Test 1 covers idle outputs and MDC activity inside the hold-off window
		check_eq(rd_valid, 1'b0, "rd_valid after reset");
		check_eq(mdio_oe, 3'b000, "mdio_oe after reset");
		check_eq(mdio_out, 3'b111, "mdio_out after reset");
		seen = '0;
		for (int i = 0; i < `MDIO_HOLDOFF; i++) begin
			seen = seen | mdc;
			@(negedge sys_clk);
		end
		check_eq(seen, 3'b101, "MDC activity during hold-off");
		n = 0;
		while (!mdc[1] && n < 100) begin
			@(negedge sys_clk);
			n++;
		end
		if (!mdc[1]) begin
			errors++;
			$display("Channel 1 MDC never started after the hold-off");
		end
		for (int ch = 0; ch < `MDIO_CHANNELS; ch++) begin
			bus_read(reg_addr(ch, REG_STATUS), rd);
			check_eq(rd, 8'h00, $sformatf("ch%0d status after reset", ch));
		end
		finish_test("Test 1 reset state");

		// Test 2 runs one random write frame per channel
		for (int ch = 0; ch < `MDIO_CHANNELS; ch++) begin
			r = next_rand();
			exp_phy[ch] = r[20:16];
			exp_reg[ch] = r[28:24];
			r = next_rand();
			exp_dat[ch] = r[31:16];
			base_fr[ch] = m_frames[ch];
			load_write(ch);
			bus_write(reg_addr(ch, REG_CMD), {3'b100, exp_reg[ch]});
			wait_busy(ch, 1'b1);
			wait_busy(ch, 1'b0);
			check_write(ch, base_fr[ch]);
		end
		finish_test("Test 2 MDIO write");

		// Test 3 reads back the written register and an untouched neighbour
		for (int ch = 0; ch < `MDIO_CHANNELS; ch++) begin
			read_and_check(ch, exp_reg[ch], exp_dat[ch]);
			alt = exp_reg[ch] ^ 5'd1;
			read_and_check(ch, alt, 16'(alt) * 16'h0101 + 16'(ch));
		end
		finish_test("Test 3 MDIO read");

		// Test 4 reads unmapped space while read data registers hold nonzero values
		for (int ch = 0; ch < `MDIO_CHANNELS; ch++) begin
			bus_read(reg_addr(ch, 3'd7), rd);
			check_eq(rd, 8'h00, $sformatf("ch%0d offset 7", ch));
		end
		r = next_rand();
		for (int k = 0; k < 4; k++) begin
			n = `MDIO_CHANNELS + int'(r[19:16]) + k;
			bus_read(reg_addr(n, REG_RDATA_LO), rd);
			check_eq(rd, 8'h00, $sformatf("read data low of missing channel %0d", n));
			bus_read(reg_addr(n, REG_RDATA_HI), rd);
			check_eq(rd, 8'h00, $sformatf("read data high of missing channel %0d", n));
		end
		finish_test("Test 4 bus read timing and unmapped reads");

		// Test 5 gives each channel its own PHY address range so crosstalk shows up
		for (int ch = 0; ch < `MDIO_CHANNELS; ch++) begin
			r = next_rand();
			exp_phy[ch] = {2'(ch), r[18:16]};
			exp_reg[ch] = r[28:24];
			r = next_rand();
			exp_dat[ch] = r[31:16];
			base_fr[ch] = m_frames[ch];
			load_write(ch);
		end
		for (int ch = 0; ch < `MDIO_CHANNELS; ch++) begin
			bus_write(reg_addr(ch, REG_CMD), {3'b100, exp_reg[ch]});
		end
		for (int ch = 0; ch < `MDIO_CHANNELS; ch++) begin
			wait_busy(ch, 1'b1);
		end
		for (int ch = 0; ch < `MDIO_CHANNELS; ch++) begin
			wait_busy(ch, 1'b0);
			check_write(ch, base_fr[ch]);
		end
		finish_test("Test 5 concurrent channels");

		$display("Tests run: %0d, errors: %0d", tests, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+src
src/mgmt_pkg.sv
src/mdio_reg_decoder.sv
src/mdio_master.sv
src/mdio_readback_mux.sv
src/mgmt_mdio_top.sv
sim/mdio_phy_model.sv
sim/tb_mgmt_mdio.sv
